//--- src/hostBusPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host bus definitions
// Cycle kinds seen on the CPU pin bus plus the memory and port map
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package hostBusPkg;

    // Kind of CPU bus cycle after strobe decoding
    typedef enum logic [2:0] {
        cycIdle     = 3'd0,
        cycMemRead  = 3'd1,
        cycMemWrite = 3'd2,
        cycIoRead   = 3'd3,
        cycIoWrite  = 3'd4,
        cycRefresh  = 3'd5
    } busCycleT;

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory map
    // ~~~~~~~~~~~~~~~~~~~~

    // RAM decodes the low 10 address bits, 1 KB block at the bottom
    localparam int RamBlockBits = 10;

    // ~~~~~~~~~~~~~~~~~~~~
    // I/O map, port number lives on A15..A8
    // ~~~~~~~~~~~~~~~~~~~~

    // UART transmit data, write only
    localparam logic [7:0] UartDataPort = 8'h01;

    // UART status, bit 0 is transmitter busy
    localparam logic [7:0] UartStatusPort = 8'h02;

endpackage

`default_nettype wire

//--- src/uartPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// UART definitions
// Transmitter states and 8N1 frame constants
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uartPkg;

    // Transmitter FSM states
    typedef enum logic [1:0] {
        uartIdle  = 2'd0,
        uartStart = 2'd1,
        uartData  = 2'd2,
        uartStop  = 2'd3
    } uartStateT;

    // Data bits per frame, sent LSB first
    localparam int FrameDataBits = 8;

    // Line level of the start bit
    localparam logic StartBitLevel = 1'b0;

    // Line level of the stop bit, also the idle level
    localparam logic StopBitLevel = 1'b1;

endpackage

`default_nettype wire

//--- src/clockReset.sv
// ~~~~~~~~~~~~~~~~~~~~
// Reset synchronizer and baud tick
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module clockReset #(
    parameter int ClksPerBit = 16
) (
    input  wire logic clk,
    input  wire logic rstN,
    output logic      syncRstN,
    output logic      baudTick
);

    // Counter needs at least one bit
    localparam int CntBits = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;

    logic [1:0]         rstSync;
    logic [CntBits-1:0] baudCnt;

    // ~~~~~~~~~~~~~~~~~~~~
    // Reset synchronizer
    // ~~~~~~~~~~~~~~~~~~~~

    // Assert at once, release two edges after rstN rises
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rstSync <= 2'b00;
        end else begin
            rstSync <= {rstSync[0], 1'b1};
        end
    end

    assign syncRstN = rstSync[1];

    // ~~~~~~~~~~~~~~~~~~~~
    // Baud rate enable
    // ~~~~~~~~~~~~~~~~~~~~

    // Free running, one tick per bit period
    always_ff @(posedge clk or negedge syncRstN) begin
        if (!syncRstN) begin
            baudCnt  <= '0;
            baudTick <= 1'b0;
        end else begin
            baudTick <= (baudCnt == CntBits'(ClksPerBit - 1));
            if (baudCnt == CntBits'(ClksPerBit - 1)) begin
                baudCnt <= '0;
            end else begin
                baudCnt <= baudCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/busDecode.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU bus cycle decoder
// Syncs the strobes, issues one request per cycle and muxes read data
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module busDecode #(
    parameter int AddrWidth = 16,
    parameter int DataWidth = 8
) (
    input  wire logic                                 clk,
    input  wire logic                                 syncRstN,
    input  wire logic [AddrWidth-1:0]                 addr,
    input  wire logic [DataWidth-1:0]                 dataIn,
    input  wire logic                                 nMreq,
    input  wire logic                                 nIorq,
    input  wire logic                                 nRd,
    input  wire logic                                 nWr,
    input  wire logic                                 nRfsh,
    input  wire logic [DataWidth-1:0]                 ramQ,
    input  wire logic                                 txBusy,
    output logic      [DataWidth-1:0]                 dataOut,
    output logic                                      dataOe,
    output logic      [hostBusPkg::RamBlockBits-1:0]  ramAddr,
    output logic      [DataWidth-1:0]                 ramWData,
    output logic                                      ramWe,
    output logic                                      txLoad,
    output logic      [DataWidth-1:0]                 txData
);

    // Bit positions in the strobe vector
    localparam int IdxMreq = 4;
    localparam int IdxIorq = 3;
    localparam int IdxRd   = 2;
    localparam int IdxWr   = 1;
    localparam int IdxRfsh = 0;

    logic [4:0]           strobeS1;
    logic [4:0]           strobeS2;
    hostBusPkg::busCycleT cycNow;
    hostBusPkg::busCycleT cycPrev;
    logic                 cycEntry;
    logic                 ramHit;
    logic [7:0]           portNum;
    logic                 oeRam;
    logic                 oeStatus;
    logic [DataWidth-1:0] wDataQ;

    // Strobes are active low, refresh wins over everything
    function automatic hostBusPkg::busCycleT classify(input logic [4:0] s);
        hostBusPkg::busCycleT kind;
        kind = hostBusPkg::cycIdle;
        if (!s[IdxRfsh]) kind = hostBusPkg::cycRefresh;
        else if (!s[IdxMreq] && !s[IdxRd]) kind = hostBusPkg::cycMemRead;
        else if (!s[IdxMreq] && !s[IdxWr]) kind = hostBusPkg::cycMemWrite;
        else if (!s[IdxIorq] && !s[IdxRd]) kind = hostBusPkg::cycIoRead;
        else if (!s[IdxIorq] && !s[IdxWr]) kind = hostBusPkg::cycIoWrite;
        return kind;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~
    assign cycNow   = classify(strobeS2);
    // First cycle of a new bus cycle
    assign cycEntry = (cycNow != hostBusPkg::cycIdle) && (cycPrev == hostBusPkg::cycIdle);
    // Only the lowest 1 KB block is populated
    assign ramHit   = (addr[AddrWidth-1:hostBusPkg::RamBlockBits] == '0);
    assign portNum  = addr[AddrWidth-1 -: 8];
    assign ramAddr  = addr[hostBusPkg::RamBlockBits-1:0];

    always_ff @(posedge clk or negedge syncRstN) begin
        if (!syncRstN) begin
            strobeS1 <= '1;
            strobeS2 <= '1;
            cycPrev  <= hostBusPkg::cycIdle;
            ramWe    <= 1'b0;
            txLoad   <= 1'b0;
            oeRam    <= 1'b0;
            oeStatus <= 1'b0;
        end else begin
            // Two stage sync of the asynchronous CPU strobes
            strobeS1 <= {nMreq, nIorq, nRd, nWr, nRfsh};
            strobeS2 <= strobeS1;
            cycPrev  <= cycNow;
            ramWe    <= cycEntry && (cycNow == hostBusPkg::cycMemWrite) && ramHit;
            txLoad   <= cycEntry && (cycNow == hostBusPkg::cycIoWrite) &&
                        (portNum == hostBusPkg::UartDataPort);
            // Read drive holds for the whole cycle
            if (cycEntry) begin
                oeRam    <= (cycNow == hostBusPkg::cycMemRead) && ramHit;
                oeStatus <= (cycNow == hostBusPkg::cycIoRead) &&
                            (portNum == hostBusPkg::UartStatusPort);
            end else if (cycNow == hostBusPkg::cycIdle) begin
                oeRam    <= 1'b0;
                oeStatus <= 1'b0;
            end
        end
    end

    // Write byte captured together with the request
    always_ff @(posedge clk) begin
        if (cycEntry) begin
            wDataQ <= dataIn;
        end
    end

    assign ramWData = wDataQ;
    assign txData   = wDataQ;

    // ~~~~~~~~~~~~~~~~~~~~
    // Read data
    // ~~~~~~~~~~~~~~~~~~~~
    assign dataOe = oeRam | oeStatus;

    always_comb begin
        if (oeStatus) dataOut = {{(DataWidth-1){1'b0}}, txBusy};
        else if (oeRam) dataOut = ramQ;
        else dataOut = '0;
    end

endmodule

`default_nettype wire

//--- src/hostRam.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host RAM, 1 KB single port
// Synchronous write, registered read
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hostRam #(
    parameter int AddrWidth = hostBusPkg::RamBlockBits,
    parameter int DataWidth = 8
) (
    input  wire logic                 clk,
    input  wire logic [AddrWidth-1:0] ramAddr,
    input  wire logic [DataWidth-1:0] ramWData,
    input  wire logic                 ramWe,
    output logic      [DataWidth-1:0] ramQ
);

    // Number of words follows the address width
    localparam int Depth = 2 ** AddrWidth;

    logic [DataWidth-1:0] mem [Depth];

    // ~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWData;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~

    // Old data on a same cycle write, one cycle latency
    always_ff @(posedge clk) begin
        ramQ <= mem[ramAddr];
    end

endmodule

`default_nettype wire

//--- src/uartTx.sv
// ~~~~~~~~~~~~~~~~~~~~
// UART transmitter, 8N1
// Sends one byte per load on the baud tick, busy while framing
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module uartTx (
    input  wire logic                               clk,
    input  wire logic                               syncRstN,
    input  wire logic                               baudTick,
    input  wire logic                               txLoad,
    input  wire logic [uartPkg::FrameDataBits-1:0]  txData,
    output logic                                    txBusy,
    output logic                                    txd
);

    // Counter also covers the stop bit step
    localparam int CntBits = $clog2(uartPkg::FrameDataBits + 1);

    uartPkg::uartStateT                  state;
    logic [uartPkg::FrameDataBits-1:0]   shiftReg;
    logic [CntBits-1:0]                  bitCnt;

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge syncRstN) begin
        if (!syncRstN) begin
            state  <= uartPkg::uartIdle;
            bitCnt <= '0;
            txd    <= uartPkg::StopBitLevel;
        end else begin
            case (state)
                uartPkg::uartIdle: begin
                    txd <= uartPkg::StopBitLevel;
                    // Byte only taken while idle, loads during a frame are lost
                    if (txLoad) begin
                        state <= uartPkg::uartStart;
                    end
                end
                uartPkg::uartStart: begin
                    // Wait for the tick so the start bit is a full period
                    if (baudTick) begin
                        txd    <= uartPkg::StartBitLevel;
                        bitCnt <= '0;
                        state  <= uartPkg::uartData;
                    end
                end
                uartPkg::uartData: begin
                    if (baudTick) begin
                        // Last step puts the stop bit out, the shifter fills with it
                        txd <= shiftReg[0];
                        if (bitCnt == CntBits'(uartPkg::FrameDataBits)) begin
                            state <= uartPkg::uartStop;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
                uartPkg::uartStop: begin
                    // Stop bit held for one period, then free
                    if (baudTick) begin
                        txd   <= uartPkg::StopBitLevel;
                        state <= uartPkg::uartIdle;
                    end
                end
                default: begin
                    state <= uartPkg::uartIdle;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Shift register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == uartPkg::uartIdle && txLoad) begin
            shiftReg <= txData;
        end else if (state == uartPkg::uartData && baudTick) begin
            // LSB first
            shiftReg <= {uartPkg::StopBitLevel, shiftReg[uartPkg::FrameDataBits-1:1]};
        end
    end

    assign txBusy = (state != uartPkg::uartIdle);

endmodule

`default_nettype wire

//--- src/hostTop.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host peripheral top
// RAM and UART behind a Z80 style pin bus
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hostTop #(
    parameter int ClksPerBit = 16,
    parameter int AddrWidth  = 16,
    parameter int DataWidth  = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic [AddrWidth-1:0] addr,
    input  wire logic [DataWidth-1:0] dataIn,
    input  wire logic                 nMreq,
    input  wire logic                 nIorq,
    input  wire logic                 nRd,
    input  wire logic                 nWr,
    input  wire logic                 nRfsh,
    // Kept for pin compatibility, opcode fetch needs no special handling here
    input  wire logic                 nM1,
    output logic      [DataWidth-1:0] dataOut,
    output logic                      dataOe,
    output logic                      txd
);

    logic                                syncRstN;
    logic                                baudTick;
    logic [hostBusPkg::RamBlockBits-1:0] ramAddr;
    logic [DataWidth-1:0]                ramWData;
    logic                                ramWe;
    logic [DataWidth-1:0]                ramQ;
    logic                                txLoad;
    logic [DataWidth-1:0]                txData;
    logic                                txBusy;

    // ~~~~~~~~~~~~~~~~~~~~
    // Reset and baud tick
    // ~~~~~~~~~~~~~~~~~~~~
    clockReset #(
        .ClksPerBit(ClksPerBit)
    ) uClockReset (
        .clk     (clk),
        .rstN    (rstN),
        .syncRstN(syncRstN),
        .baudTick(baudTick)
    );

    // Bus side
    busDecode #(
        .AddrWidth(AddrWidth),
        .DataWidth(DataWidth)
    ) uBusDecode (
        .clk(clk), .syncRstN(syncRstN), .addr(addr), .dataIn(dataIn),
        .nMreq(nMreq), .nIorq(nIorq), .nRd(nRd), .nWr(nWr), .nRfsh(nRfsh),
        .ramQ(ramQ), .txBusy(txBusy), .dataOut(dataOut), .dataOe(dataOe),
        .ramAddr(ramAddr), .ramWData(ramWData), .ramWe(ramWe),
        .txLoad(txLoad), .txData(txData)
    );

    // 1 KB at the bottom of memory
    hostRam #(
        .AddrWidth(hostBusPkg::RamBlockBits),
        .DataWidth(DataWidth)
    ) uHostRam (
        .clk(clk), .ramAddr(ramAddr), .ramWData(ramWData), .ramWe(ramWe), .ramQ(ramQ)
    );

    // Serial output
    uartTx uUartTx (
        .clk(clk), .syncRstN(syncRstN), .baudTick(baudTick), .txLoad(txLoad),
        .txData(txData), .txBusy(txBusy), .txd(txd)
    );

endmodule

`default_nettype wire

//--- sim/hostTop_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host top bound checks
// Bus drive on writes, UART idle level, request exclusivity
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hostTopAsserts (
    input  wire logic               clk,
    input  wire logic               syncRstN,
    input  var hostBusPkg::busCycleT cycNow,
    input  wire logic               dataOe,
    input  wire logic               txBusy,
    input  var uartPkg::uartStateT  txState,
    input  wire logic               txd,
    input  wire logic               ramWe,
    input  wire logic               txLoad
);

    // Data bus is never driven while a write is decoded
    noDriveOnWrite: assert property (@(posedge clk) disable iff (!syncRstN)
        (cycNow == hostBusPkg::cycMemWrite || cycNow == hostBusPkg::cycIoWrite) |-> !dataOe)
        else $error("dataOe high during a write cycle");

    // Line sits at the stop level while free or waiting for the start tick
    idleLineHigh: assert property (@(posedge clk) disable iff (!syncRstN)
        (!txBusy || txState == uartPkg::uartStart) |-> txd)
        else $error("txd low while the transmitter is idle or waiting to start");

    // One request per bus cycle, never both targets
    oneRequest: assert property (@(posedge clk) disable iff (!syncRstN)
        !(ramWe && txLoad))
        else $error("ramWe and txLoad high in the same cycle");

endmodule

bind hostTop hostTopAsserts uHostTopAsserts (
    .clk(clk), .syncRstN(syncRstN), .cycNow(uBusDecode.cycNow), .dataOe(dataOe),
    .txBusy(txBusy), .txState(uUartTx.state), .txd(txd), .ramWe(ramWe), .txLoad(txLoad)
);

`default_nettype wire

//--- sim/hostTb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host top testbench
// Plays the CPU on the pin bus and captures UART frames
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module hostTb;

    localparam int ClksPerBit    = 16;
    localparam int ClkPeriod     = 100;
    localparam int BusCycleClks  = 10;
    // Frame plus the wait for the first baud tick
    localparam int FrameClks     = (uartPkg::FrameDataBits + 3) * ClksPerBit;
    localparam int NumTests      = 6;
    localparam int WatchdogClks  = NumTests * (3 * FrameClks + 40 * BusCycleClks);
    // Data write on the bus plus at most one bit period until the start tick
    localparam int StartWaitClks = BusCycleClks + ClksPerBit;

    logic        clk = 1'b0;
    logic        rstN;
    logic [15:0] addr;
    logic [7:0]  dataIn;
    logic        nMreq;
    logic        nIorq;
    logic        nRd;
    logic        nWr;
    logic        nRfsh;
    logic        nM1;
    logic [7:0]  dataOut;
    logic        dataOe;
    logic        txd;

    logic [31:0] lfsrState;
    logic [7:0]  ramModel [1024];
    int          errCount;
    int          checkCount;
    int          testCount;
    int          testErrBase;

    hostTop #(.ClksPerBit(ClksPerBit), .AddrWidth(16), .DataWidth(8)) uut (
        .clk(clk), .rstN(rstN), .addr(addr), .dataIn(dataIn), .nMreq(nMreq),
        .nIorq(nIorq), .nRd(nRd), .nWr(nWr), .nRfsh(nRfsh), .nM1(nM1),
        .dataOut(dataOut), .dataOe(dataOe), .txd(txd)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    task automatic checkValue(input logic [7:0] got, input logic [7:0] exp, input string what);
        checkCount++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %02h, expected %02h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checkCount++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            errCount++;
        end
    endtask

    // Address one cycle ahead, strobes held 5 cycles, sampled in the last one
    task automatic runBusCycle(input logic isIo, input logic isRead, input logic isRfsh,
                               input logic [15:0] a, input logic [7:0] d,
                               output logic [7:0] q, output logic oe);
        @(posedge clk);
        #10;
        addr   = a;
        dataIn = d;
        @(posedge clk);
        #10;
        if (isRfsh) nRfsh = 1'b0;
        if (isIo) nIorq = 1'b0;
        else nMreq = 1'b0;
        if (isRead) nRd = 1'b0;
        else nWr = 1'b0;
        repeat (4) @(posedge clk);
        #20;
        q  = dataOut;
        oe = dataOe;
        @(posedge clk);
        #10;
        {nMreq, nIorq, nRd, nWr, nRfsh} = '1;
        // Idle gap before the next cycle
        repeat (3) @(posedge clk);
    endtask

    task automatic memWrite(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] q;
        logic       oe;
        runBusCycle(1'b0, 1'b0, 1'b0, a, d, q, oe);
    endtask

    task automatic memRead(input logic [15:0] a, output logic [7:0] q, output logic oe);
        runBusCycle(1'b0, 1'b1, 1'b0, a, 8'h00, q, oe);
    endtask

    task automatic ioWrite(input logic [7:0] port, input logic [7:0] d);
        logic [7:0] q;
        logic       oe;
        runBusCycle(1'b1, 1'b0, 1'b0, {port, 8'h00}, d, q, oe);
    endtask

    task automatic ioRead(input logic [7:0] port, output logic [7:0] q, output logic oe);
        runBusCycle(1'b1, 1'b1, 1'b0, {port, 8'h00}, 8'h00, q, oe);
    endtask

    // Refresh with nWr low as well, must not touch the RAM
    task automatic refreshCycle(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] q;
        logic       oe;
        runBusCycle(1'b0, 1'b0, 1'b1, a, d, q, oe);
    endtask

    // Samples each bit in its middle, returns at the end of the stop bit
    task automatic uartCapture(input logic [7:0] expByte);
        int         waited;
        logic [7:0] got;
        waited = 0;
        got    = '0;
        while (txd === 1'b1 && waited < StartWaitClks) begin
            @(posedge clk);
            #20;
            waited++;
        end
        assert (txd === 1'b0) else begin
            $display("No start bit appeared on txd within %0d clock cycles", StartWaitClks);
            errCount++;
        end
        if (txd === 1'b0) begin
            repeat (ClksPerBit / 2) @(posedge clk);
            #20;
            checkBit(txd, 1'b0, "start bit");
            for (int i = 0; i < uartPkg::FrameDataBits; i++) begin
                repeat (ClksPerBit) @(posedge clk);
                #20;
                got[i] = txd;
            end
            repeat (ClksPerBit) @(posedge clk);
            #20;
            checkBit(txd, 1'b1, "stop bit");
            checkValue(got, expByte, "frame byte");
            repeat (ClksPerBit / 2) @(posedge clk);
        end
    endtask

    task automatic checkLineIdle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #20;
            if (txd !== 1'b1) checkBit(txd, 1'b1, "txd with no frame pending");
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount == testErrBase) $display("Test %0d %s: passed", testCount, name);
        else $display("Test %0d %s: %0d errors", testCount, name, errCount - testErrBase);
        testErrBase = errCount;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic testReset();
        logic [7:0] q;
        logic       oe;
        checkBit(txd, 1'b1, "txd after reset");
        checkBit(dataOe, 1'b0, "dataOe after reset");
        ioRead(hostBusPkg::UartStatusPort, q, oe);
        checkValue(q, 8'h00, "status after reset");
        checkBit(oe, 1'b1, "dataOe on status read");
        finishTest("reset state");
    endtask

    task automatic testRamReadback();
        logic [9:0]  addrList [16];
        logic [31:0] r;
        logic [7:0]  q;
        logic        oe;
        for (int i = 0; i < 16; i++) begin
            randBits(10, r);
            addrList[i] = r[9:0];
            randBits(8, r);
            ramModel[addrList[i]] = r[7:0];
            memWrite({6'b0, addrList[i]}, r[7:0]);
        end
        for (int i = 0; i < 16; i++) begin
            memRead({6'b0, addrList[i]}, q, oe);
            checkValue(q, ramModel[addrList[i]], "RAM readback");
            checkBit(oe, 1'b1, "dataOe on RAM read");
        end
        finishTest("RAM readback");
    endtask

    task automatic testAliasing();
        logic [31:0] r;
        logic [9:0]  base;
        logic [5:0]  hi;
        logic [7:0]  q;
        logic        oe;
        randBits(10, r);
        base = r[9:0];
        randBits(8, r);
        ramModel[base] = r[7:0];
        memWrite({6'b0, base}, r[7:0]);
        randBits(6, r);
        hi = (r[5:0] == 6'd0) ? 6'd1 : r[5:0];
        // Upper block must not alias onto the RAM
        memWrite({hi, base}, ~ramModel[base]);
        memRead({6'b0, base}, q, oe);
        checkValue(q, ramModel[base], "RAM after out of range write");
        memRead({hi, base}, q, oe);
        checkBit(oe, 1'b0, "dataOe on out of range read");
        refreshCycle({6'b0, base}, ramModel[base] ^ 8'h5a);
        memRead({6'b0, base}, q, oe);
        checkValue(q, ramModel[base], "RAM after refresh cycle");
        finishTest("address decode");
    endtask

    task automatic testFrame();
        logic [31:0] r;
        randBits(8, r);
        fork
            ioWrite(hostBusPkg::UartDataPort, r[7:0]);
            uartCapture(r[7:0]);
        join
        finishTest("UART frame");
    endtask

    task automatic testDroppedWrite();
        logic [31:0] r;
        logic [7:0]  q;
        logic        oe;
        randBits(8, r);
        fork
            begin
                ioWrite(hostBusPkg::UartDataPort, r[7:0]);
                ioRead(hostBusPkg::UartStatusPort, q, oe);
                checkValue(q, 8'h01, "status during frame");
                checkBit(oe, 1'b1, "dataOe on status read");
                // Sent while busy, must be lost
                ioWrite(hostBusPkg::UartDataPort, ~r[7:0]);
            end
            uartCapture(r[7:0]);
        join
        ioRead(hostBusPkg::UartStatusPort, q, oe);
        checkValue(q, 8'h00, "status after frame");
        checkLineIdle(2 * FrameClks);
        finishTest("busy drop");
    endtask

    task automatic testUnmapped();
        logic [31:0] r;
        logic [7:0]  q;
        logic        oe;
        ioRead(8'h05, q, oe);
        checkBit(oe, 1'b0, "dataOe on unmapped port read");
        randBits(8, r);
        fork
            ioWrite(hostBusPkg::UartDataPort, r[7:0]);
            uartCapture(r[7:0]);
        join
        finishTest("unmapped port");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        lfsrState   = 32'h638478e5;
        errCount    = 0;
        checkCount  = 0;
        testCount   = 0;
        testErrBase = 0;
        rstN   = 1'b0;
        addr   = '0;
        dataIn = '0;
        {nMreq, nIorq, nRd, nWr, nRfsh, nM1} = '1;
        repeat (8) @(posedge clk);
        #10;
        rstN = 1'b1;
        // Let the synchronized reset release
        repeat (4) @(posedge clk);
        #20;
        testReset();
        testRamReadback();
        testAliasing();
        testFrame();
        testDroppedWrite();
        testUnmapped();
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WatchdogClks * ClkPeriod);
        $display("Timeout: the tests ran longer than %0d clock cycles", WatchdogClks);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
src/hostBusPkg.sv
src/uartPkg.sv
src/clockReset.sv
src/busDecode.sv
src/hostRam.sv
src/uartTx.sv
src/hostTop.sv
sim/hostTop_asserts.sv
sim/hostTb.sv
